// ==== Bender.yml ====
package:
  name: frontend

sources:
  - common/rv32i_pkg.sv
  - common/frontend_pkg.sv
  - common/mem_bus_if.sv
  - hdl/inst_mem.sv
  - hdl/mem_arbiter.sv
  - fetch/fetch_unit.sv
  - i_queue/i_queue.sv
  - hdl/frontend_top.sv
  - target: test
    files:
      - tb/frontend_tb.sv

// ==== common/frontend_pkg.sv ====
// Memory bus widths and the instruction queue entry type

package frontend_pkg;

    // Byte address width of the shared memory bus
    localparam int addr_w = 32;

    // Data word width of the shared memory bus
    localparam int data_w = 32;

    // One queue entry as seen by decode
    typedef struct packed {
        logic [addr_w-1:0] pc;
        logic [addr_w-1:0] next_pc;
        rv32i_pkg::instr_u instr;
    } i_queue_data;

endpackage : frontend_pkg

// ==== common/mem_bus_if.sv ====
// Link between one requester and the shared memory arbiter

`timescale 1ns/1ns

interface mem_bus_if;

    // Request side
    logic                              req;
    logic                              we;
    logic [frontend_pkg::addr_w-1:0]   addr;
    logic [frontend_pkg::data_w-1:0]   wdata;

    // Grant and read response
    logic                              gnt;
    logic                              rvalid;
    logic [frontend_pkg::data_w-1:0]   rdata;

    modport requester (
        output req,
        output we,
        output addr,
        output wdata,
        input  gnt,
        input  rvalid,
        input  rdata
    );

    modport arbiter (
        input  req,
        input  we,
        input  addr,
        input  wdata,
        output gnt,
        output rvalid,
        output rdata
    );

endinterface : mem_bus_if

// ==== common/rv32i_pkg.sv ====
// RV32I opcode values, J-type and B-type instruction formats, instruction union

package rv32i_pkg;

    // Control transfer opcodes seen by the front end
    localparam logic [6:0] op_jal    = 7'b1101111;
    localparam logic [6:0] op_branch = 7'b1100011;

    // J-type with immediate bits scattered as in the ISA manual
    typedef struct packed {
        logic       imm_20;
        logic [9:0] imm_10_1;
        logic       imm_11;
        logic [7:0] imm_19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } j_fmt_t;

    // B-type with imm_12 as the sign bit
    typedef struct packed {
        logic       imm_12;
        logic [5:0] imm_10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;
        logic [6:0] opcode;
    } b_fmt_t;

    // One fetched word, viewed raw or by format
    typedef union packed {
        logic [31:0] raw;
        j_fmt_t      j;
        b_fmt_t      b;
    } instr_u;

endpackage : rv32i_pkg

// ==== fetch/fetch_unit.sv ====
// PC register, memory request sequencing, static next-PC prediction and queue writes of fetch

`timescale 1ns/1ns

module fetch_unit (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              run,
    input  logic [frontend_pkg::addr_w-1:0]   reset_pc,
    input  logic [frontend_pkg::addr_w-1:0]   redirect_pc,
    input  logic                              flush,
    mem_bus_if.requester                      bus,
    input  logic                              full,
    output logic                              write,
    output frontend_pkg::i_queue_data         data_in
);

    logic [frontend_pkg::addr_w-1:0] pc;
    logic [frontend_pkg::addr_w-1:0] pred_pc;
    logic [31:0]                     j_imm;
    logic [31:0]                     b_imm;
    rv32i_pkg::instr_u               word;
    logic                            pending;
    logic                            discard;
    logic                            take;

    // One request in flight at most
    assign bus.req   = run && !full && !pending;
    assign bus.we    = 1'b0;
    assign bus.addr  = pc;
    assign bus.wdata = '0;

    assign take = bus.req && bus.gnt;

    // Returned word, decoded both ways below
    assign word = bus.rdata;

    assign j_imm = {{11{word.j.imm_20}}, word.j.imm_20, word.j.imm_19_12,
                    word.j.imm_11, word.j.imm_10_1, 1'b0};
    assign b_imm = {{19{word.b.imm_12}}, word.b.imm_12, word.b.imm_11,
                    word.b.imm_10_5, word.b.imm_4_1, 1'b0};

    // JAL and backward branches taken and the rest fall through
    always_comb begin
        if (word.j.opcode == rv32i_pkg::op_jal) begin
            pred_pc = pc + j_imm;
        end else if (word.b.opcode == rv32i_pkg::op_branch && word.b.imm_12) begin
            pred_pc = pc + b_imm;
        end else begin
            pred_pc = pc + 32'd4;
        end
    end

    // Queue entry is written in the response cycle
    assign write           = bus.rvalid && !discard && !flush;
    assign data_in.pc      = pc;
    assign data_in.next_pc = pred_pc;
    assign data_in.instr   = word;

    always_ff @(posedge clk) begin
        if (rst) begin
            pc      <= reset_pc;
            pending <= 1'b0;
            discard <= 1'b0;
        end else begin
            if (take) begin
                pending <= 1'b1;
            end else if (bus.rvalid) begin
                pending <= 1'b0;
            end

            if (flush) begin
                pc <= redirect_pc;
                // Response of an old request must not reach the queue
                discard <= take;
            end else if (bus.rvalid) begin
                discard <= 1'b0;
                if (!discard) begin
                    pc <= pred_pc;
                end
            end
        end
    end

endmodule : fetch_unit

// ==== frontend_top.f ====
common/rv32i_pkg.sv
common/frontend_pkg.sv
common/mem_bus_if.sv
hdl/inst_mem.sv
hdl/mem_arbiter.sv
fetch/fetch_unit.sv
i_queue/i_queue.sv
hdl/frontend_top.sv
tb/frontend_tb.sv

// ==== hdl/frontend_top.sv ====
// Front end top level with fetch unit, instruction queue, memory arbiter and instruction memory

`timescale 1ns/1ns

module frontend_top #(
    parameter int entries   = 8,
    parameter int mem_words = 256
) (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              run,
    input  logic                              flush,
    input  logic [frontend_pkg::addr_w-1:0]   reset_pc,
    input  logic [frontend_pkg::addr_w-1:0]   redirect_pc,

    // External data port
    input  logic                              data_req,
    input  logic                              data_we,
    input  logic [frontend_pkg::addr_w-1:0]   data_addr,
    input  logic [frontend_pkg::data_w-1:0]   data_wdata,
    output logic                              data_gnt,
    output logic                              data_rvalid,
    output logic [frontend_pkg::data_w-1:0]   data_rdata,

    // Decoder side of the queue
    input  logic                              iq_read,
    output logic [frontend_pkg::addr_w-1:0]   iq_pc,
    output logic [frontend_pkg::addr_w-1:0]   iq_next_pc,
    output logic [31:0]                       iq_instr,
    output logic                              iq_empty,
    output logic                              iq_full
);

    mem_bus_if fetch_bus ();
    mem_bus_if data_bus ();

    frontend_pkg::i_queue_data        iq_in;
    frontend_pkg::i_queue_data        iq_out;
    logic                             iq_write;
    logic                             mem_en;
    logic                             mem_we;
    logic [frontend_pkg::addr_w-1:0]  mem_addr;
    logic [frontend_pkg::data_w-1:0]  mem_wdata;
    logic [frontend_pkg::data_w-1:0]  mem_rdata;

    // Data port from plain pins
    assign data_bus.req   = data_req;
    assign data_bus.we    = data_we;
    assign data_bus.addr  = data_addr;
    assign data_bus.wdata = data_wdata;
    assign data_gnt       = data_bus.gnt;
    assign data_rvalid    = data_bus.rvalid;
    assign data_rdata     = data_bus.rdata;

    fetch_unit fetch_unit_inst (
        .clk         (clk),
        .rst         (rst),
        .run         (run),
        .reset_pc    (reset_pc),
        .redirect_pc (redirect_pc),
        .flush       (flush),
        .bus         (fetch_bus.requester),
        .full        (iq_full),
        .write       (iq_write),
        .data_in     (iq_in)
    );

    i_queue #(
        .entries (entries)
    ) i_queue_inst (
        .clk      (clk),
        .rst      (rst),
        .flush    (flush),
        .read     (iq_read),
        .write    (iq_write),
        .data_in  (iq_in),
        .data_out (iq_out),
        .empty    (iq_empty),
        .full     (iq_full)
    );

    mem_arbiter mem_arbiter_inst (
        .clk        (clk),
        .rst        (rst),
        .data_port  (data_bus.arbiter),
        .fetch_port (fetch_bus.arbiter),
        .mem_en     (mem_en),
        .mem_we     (mem_we),
        .mem_addr   (mem_addr),
        .mem_wdata  (mem_wdata),
        .mem_rdata  (mem_rdata)
    );

    inst_mem #(
        .mem_words (mem_words)
    ) inst_mem_inst (
        .clk   (clk),
        .en    (mem_en),
        .we    (mem_we),
        .addr  (mem_addr),
        .wdata (mem_wdata),
        .rdata (mem_rdata)
    );

    // Queue head split back into plain outputs
    assign iq_pc      = iq_out.pc;
    assign iq_next_pc = iq_out.next_pc;
    assign iq_instr   = iq_out.instr.raw;

endmodule : frontend_top

// ==== hdl/inst_mem.sv ====
// Single-port synchronous word memory with registered read data

`timescale 1ns/1ns

module inst_mem #(
    parameter int mem_words = 256
) (
    input  logic                              clk,
    input  logic                              en,
    input  logic                              we,
    input  logic [frontend_pkg::addr_w-1:0]   addr,
    input  logic [frontend_pkg::data_w-1:0]   wdata,
    output logic [frontend_pkg::data_w-1:0]   rdata
);

    localparam int idx_w = (mem_words > 1) ? $clog2(mem_words) : 1;

    logic [frontend_pkg::data_w-1:0] mem [mem_words];
    logic [idx_w-1:0]                idx;

    // Word addressed with the byte offset dropped
    assign idx = addr[idx_w+1:2];

    always_ff @(posedge clk) begin
        if (en) begin
            if (we) begin
                mem[idx] <= wdata;
            end else begin
                rdata <= mem[idx];
            end
        end
    end

endmodule : inst_mem

// ==== hdl/mem_arbiter.sv ====
// Fixed-priority memory arbiter that favours the data port over fetch and routes read responses

`timescale 1ns/1ns

module mem_arbiter (
    input  logic                              clk,
    input  logic                              rst,
    mem_bus_if.arbiter                        data_port,
    mem_bus_if.arbiter                        fetch_port,
    output logic                              mem_en,
    output logic                              mem_we,
    output logic [frontend_pkg::addr_w-1:0]   mem_addr,
    output logic [frontend_pkg::data_w-1:0]   mem_wdata,
    input  logic [frontend_pkg::data_w-1:0]   mem_rdata
);

    logic rd_pending;
    logic rd_owner_data;

    // Data port always wins
    assign data_port.gnt  = data_port.req;
    assign fetch_port.gnt = fetch_port.req && !data_port.req;

    assign mem_en    = data_port.req || fetch_port.req;
    assign mem_we    = data_port.req ? data_port.we    : fetch_port.we;
    assign mem_addr  = data_port.req ? data_port.addr  : fetch_port.addr;
    assign mem_wdata = data_port.req ? data_port.wdata : fetch_port.wdata;

    // Remember who owns next cycle's read data
    always_ff @(posedge clk) begin
        if (rst) begin
            rd_pending    <= 1'b0;
            rd_owner_data <= 1'b0;
        end else begin
            rd_pending    <= mem_en && !mem_we;
            rd_owner_data <= data_port.req;
        end
    end

    assign data_port.rvalid  = rd_pending && rd_owner_data;
    assign fetch_port.rvalid = rd_pending && !rd_owner_data;

    // Both see the same data and rvalid tells them apart
    assign data_port.rdata  = mem_rdata;
    assign fetch_port.rdata = mem_rdata;

endmodule : mem_arbiter

// ==== i_queue/i_queue.sv ====
// Circular instruction queue with flush, bypass on empty and a registered pop output

`timescale 1ns/1ns

module i_queue #(
    parameter int entries = 8
) (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       flush,
    input  logic                       read,
    input  logic                       write,
    input  frontend_pkg::i_queue_data  data_in,
    output frontend_pkg::i_queue_data  data_out,
    output logic                       empty,
    output logic                       full
);

    localparam int ptr_w = (entries > 1) ? $clog2(entries) : 1;

    frontend_pkg::i_queue_data queue [entries];

    logic [ptr_w-1:0] head_ptr;
    logic [ptr_w-1:0] tail_ptr;
    logic [ptr_w-1:0] head_ptr_next;
    logic [ptr_w-1:0] tail_ptr_next;
    logic [ptr_w:0]   counter;
    logic             do_push;
    logic             do_pop;
    logic             bypass;

    // Wrap explicitly so any depth works
    assign head_ptr_next = (head_ptr == ptr_w'(entries - 1)) ? '0 : head_ptr + 1'b1;
    assign tail_ptr_next = (tail_ptr == ptr_w'(entries - 1)) ? '0 : tail_ptr + 1'b1;

    assign empty = (counter == '0);
    assign full  = (counter == (ptr_w + 1)'(entries));

    // Read and write together on empty go straight to the output
    assign bypass  = read && write && empty;
    assign do_pop  = read && !empty;
    assign do_push = write && !bypass && (!full || do_pop);

    // Entry storage
    always_ff @(posedge clk) begin
        if (do_push && !flush) begin
            queue[tail_ptr] <= data_in;
        end
    end

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            head_ptr <= '0;
            tail_ptr <= '0;
            counter  <= '0;
            data_out <= '0;
        end else begin
            if (do_push) begin
                tail_ptr <= tail_ptr_next;
            end

            if (do_pop) begin
                data_out <= queue[head_ptr];
                head_ptr <= head_ptr_next;
            end else if (bypass) begin
                data_out <= data_in;
            end

            case ({do_push, do_pop})
                2'b10:   counter <= counter + 1'b1;
                2'b01:   counter <= counter - 1'b1;
                default: ;
            endcase
        end
    end

endmodule : i_queue

// ==== tb/frontend_tb.sv ====
// Front end testbench with clock, reset, program table, reference model, checks and report

`timescale 1ns/1ns

module frontend_tb;

    localparam int prog_len = 17;
    localparam int wait_limit = 200;

    logic        clk;
    logic        rst;
    logic        run;
    logic        flush;
    logic [31:0] reset_pc;
    logic [31:0] redirect_pc;
    logic        data_req;
    logic        data_we;
    logic [31:0] data_addr;
    logic [31:0] data_wdata;
    logic        data_gnt;
    logic        data_rvalid;
    logic [31:0] data_rdata;
    logic        iq_read;
    logic [31:0] iq_pc;
    logic [31:0] iq_next_pc;
    logic [31:0] iq_instr;
    logic        iq_empty;
    logic        iq_full;

    // Address in the upper half and instruction word in the lower half
    logic [63:0] prog [prog_len];

    integer      seed;
    int          errors;
    logic [31:0] model_pc;

    frontend_top #(
        .entries   (8),
        .mem_words (256)
    ) frontend_top_inst (
        .clk         (clk),
        .rst         (rst),
        .run         (run),
        .flush       (flush),
        .reset_pc    (reset_pc),
        .redirect_pc (redirect_pc),
        .data_req    (data_req),
        .data_we     (data_we),
        .data_addr   (data_addr),
        .data_wdata  (data_wdata),
        .data_gnt    (data_gnt),
        .data_rvalid (data_rvalid),
        .data_rdata  (data_rdata),
        .iq_read     (iq_read),
        .iq_pc       (iq_pc),
        .iq_next_pc  (iq_next_pc),
        .iq_instr    (iq_instr),
        .iq_empty    (iq_empty),
        .iq_full     (iq_full)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            errors++;
            $display("FAILED %s: got %h, expected %h", name, got, exp);
            $display("Finished with errors");
            $fatal(1, "stopping at the first mismatch");
        end
    endtask

    task automatic report_timeout(input string what);
        $display("Timed out while waiting for %s", what);
        $display("Finished with errors");
        $fatal(1, "wait limit reached");
    endtask

    // Reference memory contents from the program table
    function automatic logic [31:0] table_word(input logic [31:0] addr);
        for (int i = 0; i < prog_len; i++) begin
            if (prog[i][63:32] == addr) begin
                return prog[i][31:0];
            end
        end
        return 32'h0;
    endfunction

    // JAL and backward branches taken and everything else at pc + 4
    function automatic logic [31:0] predict_next(input logic [31:0] pc,
                                                 input logic [31:0] instr);
        logic [31:0] imm;
        if (instr[6:0] == 7'b1101111) begin
            imm = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
            return pc + imm;
        end else if (instr[6:0] == 7'b1100011 && instr[31]) begin
            imm = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
            return pc + imm;
        end
        return pc + 32'd4;
    endfunction

    task automatic data_access(input logic we, input logic [31:0] addr,
                               input logic [31:0] wdata, output logic [31:0] rdata);
        int cycles;
        cycles = 0;
        @(posedge clk);
        data_req   <= 1'b1;
        data_we    <= we;
        data_addr  <= addr;
        data_wdata <= wdata;
        @(negedge clk);
        while (!data_gnt) begin
            cycles++;
            if (cycles > wait_limit) report_timeout("the data port grant");
            @(negedge clk);
        end
        @(posedge clk);
        data_req <= 1'b0;
        data_we  <= 1'b0;
        rdata = 32'h0;
        if (!we) begin
            cycles = 0;
            @(negedge clk);
            while (!data_rvalid) begin
                cycles++;
                if (cycles > wait_limit) report_timeout("the data port read response");
                @(negedge clk);
            end
            rdata = data_rdata;
        end
    endtask

    task automatic data_read_check(input int idx);
        logic [31:0] rdata;
        data_access(1'b0, prog[idx][63:32], 32'h0, rdata);
        check_value("data_rdata", rdata, prog[idx][31:0]);
    endtask

    // Pop one entry and compare it with the model's next entry
    task automatic pop_and_check();
        int          cycles;
        int          gap;
        logic [31:0] exp_instr;
        logic [31:0] exp_next;
        gap = {$random(seed)} % 3;
        repeat (gap) @(posedge clk);
        cycles = 0;
        @(negedge clk);
        while (iq_empty) begin
            cycles++;
            if (cycles > wait_limit) report_timeout("a queue entry");
            @(negedge clk);
        end
        @(posedge clk);
        iq_read <= 1'b1;
        @(posedge clk);
        iq_read <= 1'b0;
        @(negedge clk);
        exp_instr = table_word(model_pc);
        exp_next  = predict_next(model_pc, exp_instr);
        check_value("iq_pc", iq_pc, model_pc);
        check_value("iq_instr", iq_instr, exp_instr);
        check_value("iq_next_pc", iq_next_pc, exp_next);
        model_pc = exp_next;
    endtask

    task automatic flush_to(input logic [31:0] target);
        @(posedge clk);
        flush       <= 1'b1;
        redirect_pc <= target;
        @(posedge clk);
        flush <= 1'b0;
        @(negedge clk);
        check_value("iq_empty after flush", {31'h0, iq_empty}, 32'h1);
        model_pc = target;
    endtask

    initial begin
        logic [31:0] rdata;
        int          cycles;
        seed      = 14244;
        errors    = 0;
        model_pc  = 32'h0;

        rst         <= 1'b1;
        run         <= 1'b0;
        flush       <= 1'b0;
        reset_pc    <= 32'h0;
        redirect_pc <= 32'h0;
        data_req    <= 1'b0;
        data_we     <= 1'b0;
        data_addr   <= 32'h0;
        data_wdata  <= 32'h0;
        iq_read     <= 1'b0;

        // Loop with a forward branch, a JAL and a backward branch back to 0x08
        prog[0]  = {32'h00, 32'h00100093};
        prog[1]  = {32'h04, 32'h00200113};
        prog[2]  = {32'h08, 32'h00300193};
        prog[3]  = {32'h0c, 32'h00000463};
        prog[4]  = {32'h10, 32'h00400213};
        prog[5]  = {32'h14, 32'h00500293};
        prog[6]  = {32'h18, 32'h020000ef};
        prog[7]  = {32'h1c, 32'h00600313};
        prog[8]  = {32'h20, 32'h00700393};
        prog[9]  = {32'h24, 32'h00800413};
        prog[10] = {32'h28, 32'h00900493};
        prog[11] = {32'h2c, 32'h00a00513};
        prog[12] = {32'h30, 32'h00b00593};
        prog[13] = {32'h34, 32'h00c00613};
        prog[14] = {32'h38, 32'h00d00693};
        prog[15] = {32'h3c, 32'h00e00713};
        prog[16] = {32'h40, 32'hfc1044e3};

        repeat (4) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check_value("iq_empty", {31'h0, iq_empty}, 32'h1);
        check_value("iq_full", {31'h0, iq_full}, 32'h0);

        for (int i = 0; i < prog_len; i++) begin
            data_access(1'b1, prog[i][63:32], prog[i][31:0], rdata);
        end
        data_read_check(6);
        data_read_check(16);

        @(posedge clk);
        run <= 1'b1;

        // Sequential code, JAL and both branch kinds
        for (int i = 0; i < 20; i++) pop_and_check();

        // Stall the decoder until the queue fills
        repeat (60) @(posedge clk);
        cycles = 0;
        @(negedge clk);
        while (!iq_full) begin
            cycles++;
            if (cycles > wait_limit) report_timeout("the queue to become full");
            @(negedge clk);
        end
        for (int i = 0; i < 24; i++) pop_and_check();

        // Data port reads mixed with fetch traffic
        for (int i = 0; i < 12; i++) begin
            data_read_check({$random(seed)} % prog_len);
            pop_and_check();
        end

        flush_to(32'h1c);
        pop_and_check();
        for (int i = 0; i < 12; i++) pop_and_check();

        // Flush right after a pop while a fetch response is due
        flush_to(32'h00);
        for (int i = 0; i < 10; i++) pop_and_check();

        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule : frontend_tb
